/* hdl/fan_params.svh */
`ifndef FAN_PARAMS_SVH
`define FAN_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// pwm
////////////////////////////////////////////////////////////////////////////
`define FAN_PWM_PERIOD       100    // clocks per pwm period
`define FAN_DUTY_1           30     // speed 1 high clocks
`define FAN_DUTY_2           50
`define FAN_DUTY_3           80
`define LIGHT_DUTY_1         33     // mood light low
`define LIGHT_DUTY_2         66
`define LIGHT_DUTY_3         99

////////////////////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////////////////////
`define MS_PER_SEC           1000
`define TIMER_SELECT_MS      500    // preset choice window
`define TIMER_PRESET_1       1      // minutes
`define TIMER_PRESET_2       3
`define TIMER_PRESET_3       5
`define SCAN_CLKS            16     // clocks per lit digit
`define CLKS_PER_MS_DEFAULT  100000 // 100 MHz board clock

`endif

/* hdl/fan_ctrl_pkg.sv */
`default_nettype none

package fan_ctrl_pkg;

    typedef enum logic [1:0] {
        FAN_OFF, FAN_SLOW, FAN_MID, FAN_FAST
    } fan_level_e;

    typedef enum logic [1:0] {
        LIGHT_OFF, LIGHT_LOW, LIGHT_MID, LIGHT_HIGH
    } light_level_e;

    typedef enum logic [2:0] {
        T_IDLE, T_PRESET_1, T_PRESET_2, T_PRESET_3, T_LOAD, T_RUN
    } timer_state_e;

    typedef struct packed {
        logic fan;   // one-clock press pulses
        logic light;
        logic timer;
    } button_evt_t;

endpackage

`default_nettype wire

/* hdl/fan_disp_pkg.sv */
`default_nettype none

package fan_disp_pkg;

    // mm:ss in bcd, min10 is the leftmost digit
    typedef struct packed {
        logic [3:0] min10;
        logic [3:0] min1;
        logic [3:0] sec10;
        logic [3:0] sec1;
    } bcd_time_t;

    typedef struct packed {
        logic ms;    // one pulse per millisecond
        logic sec;   // coincides with an ms pulse
    } tick_t;

endpackage

`default_nettype wire

/* hdl/tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module tick_gen import fan_disp_pkg::*; #(
    parameter int clks_per_ms = `CLKS_PER_MS_DEFAULT
) (
    input  logic  clk,
    input  logic  reset_p,
    output tick_t tick
);

    localparam int cw = $clog2(clks_per_ms + 1);
    localparam int mw = $clog2(`MS_PER_SEC + 1);
    localparam logic [cw-1:0] clk_last = cw'(clks_per_ms - 1);
    localparam logic [mw-1:0] ms_last = mw'(`MS_PER_SEC - 1);

    logic [cw-1:0] clk_cnt;
    logic [mw-1:0] ms_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_cnt <= '0;
            ms_cnt  <= '0;
            tick    <= '0;
        end else if (clk_cnt == clk_last) begin
            clk_cnt <= '0;
            tick.ms <= 1'b1;
            if (ms_cnt == ms_last) begin    // second boundary
                ms_cnt   <= '0;
                tick.sec <= 1'b1;
            end else begin
                ms_cnt   <= ms_cnt + 1'b1;
                tick.sec <= 1'b0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            tick    <= '0;
        end
    end

    a_sec_with_ms: assert property (@(posedge clk) disable iff (reset_p)
        tick.sec |-> tick.ms);

endmodule

`default_nettype wire

/* hdl/button_edge.sv */
`timescale 1ns/100ps
`default_nettype none

module button_edge import fan_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset_p,
    input  logic [2:0]  btn,
    output button_evt_t press
);

    logic [2:0] sync_1;
    logic [2:0] sync_2;
    logic [2:0] prev;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_1 <= '0;
            sync_2 <= '0;
            prev   <= '0;
            press  <= '0;
        end else begin
            sync_1      <= btn;                     // two-flop synchronizer
            sync_2      <= sync_1;
            prev        <= sync_2;
            press.fan   <= sync_2[0] & ~prev[0];    // rising edges only
            press.light <= sync_2[1] & ~prev[1];
            press.timer <= sync_2[2] & ~prev[2];
        end
    end

    // a held button must never give back-to-back pulses
    a_single_pulse: assert property (@(posedge clk) disable iff (reset_p)
        (press & $past(press)) == 3'b000);

endmodule

`default_nettype wire

/* hdl/pwm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pwm_gen #(
    parameter int period = 100
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [7:0] duty,
    output logic       pwm
);

    localparam int pw = $clog2(period + 1);
    localparam int cw = (pw > 8) ? pw : 8;
    localparam logic [cw-1:0] last = cw'(period - 1);

    logic [cw-1:0] cnt;
    logic [7:0]    duty_q;  // duty held for a whole period

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cnt    <= '0;
            duty_q <= '0;
            pwm    <= 1'b0;
        end else begin
            if (cnt == last) begin
                cnt    <= '0;
                duty_q <= duty;     // new duty from the next period start
            end else begin
                cnt <= cnt + 1'b1;
            end
            pwm <= (cnt < cw'(duty_q));
        end
    end

endmodule

`default_nettype wire

/* hdl/fan_speed_fsm.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module fan_speed_fsm import fan_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  logic       press_fan,
    input  logic       finish,
    output logic       fan_on,
    output logic [2:0] status_led,
    output logic       motor_pwm
);

    fan_level_e level;
    logic [7:0] duty;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            level <= FAN_OFF;
        end else if (finish) begin
            level <= FAN_OFF;           // off-timer ran out
        end else if (press_fan) begin
            case (level)
                FAN_OFF:  level <= FAN_SLOW;
                FAN_SLOW: level <= FAN_MID;
                FAN_MID:  level <= FAN_FAST;
                default:  level <= FAN_OFF;
            endcase
        end
    end

    always_comb begin
        case (level)
            FAN_SLOW: begin
                duty       = 8'(`FAN_DUTY_1);
                status_led = 3'b001;
            end
            FAN_MID: begin
                duty       = 8'(`FAN_DUTY_2);
                status_led = 3'b010;
            end
            FAN_FAST: begin
                duty       = 8'(`FAN_DUTY_3);
                status_led = 3'b100;
            end
            default: begin
                duty       = 8'd0;
                status_led = 3'b000;
            end
        endcase
    end

    assign fan_on = (level != FAN_OFF);

    pwm_gen #(
        .period (`FAN_PWM_PERIOD)
    ) u_pwm (
        .clk     (clk),
        .reset_p (reset_p),
        .duty    (duty),
        .pwm     (motor_pwm)
    );

endmodule

`default_nettype wire

/* hdl/mood_light.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module mood_light import fan_ctrl_pkg::*; (
    input  logic clk,
    input  logic reset_p,
    input  logic press_light,
    output logic light_pwm
);

    light_level_e level;
    logic [7:0]   duty;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            level <= LIGHT_OFF;
        end else if (press_light) begin
            case (level)
                LIGHT_OFF: level <= LIGHT_LOW;
                LIGHT_LOW: level <= LIGHT_MID;
                LIGHT_MID: level <= LIGHT_HIGH;
                default:   level <= LIGHT_OFF;
            endcase
        end
    end

    always_comb begin
        case (level)
            LIGHT_LOW:  duty = 8'(`LIGHT_DUTY_1);
            LIGHT_MID:  duty = 8'(`LIGHT_DUTY_2);
            LIGHT_HIGH: duty = 8'(`LIGHT_DUTY_3);
            default:    duty = 8'd0;    // dark
        endcase
    end

    pwm_gen #(
        .period (`FAN_PWM_PERIOD)
    ) u_pwm (
        .clk     (clk),
        .reset_p (reset_p),
        .duty    (duty),
        .pwm     (light_pwm)
    );

endmodule

`default_nettype wire

/* hdl/off_timer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module off_timer import fan_ctrl_pkg::*, fan_disp_pkg::*; (
    input  logic      clk,
    input  logic      reset_p,
    input  logic      press_timer,
    input  tick_t     tick,
    input  logic      fan_on,
    output logic      finish,
    output bcd_time_t value
);

    localparam int sw = $clog2(`TIMER_SELECT_MS + 1);
    localparam logic [sw-1:0] sel_full = sw'(`TIMER_SELECT_MS);

    timer_state_e  state;
    logic [sw-1:0] sel_cnt;     // select window, in ms
    logic [3:0]    preset_min;
    bcd_time_t     run_time;

    ////////////////////////////////////////////////////////////////////////
    // preset selection and run control
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state      <= T_IDLE;
            preset_min <= 4'd0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (press_timer) begin
                        state      <= T_PRESET_1;
                        preset_min <= 4'(`TIMER_PRESET_1);
                    end
                end
                T_PRESET_1: begin
                    if (press_timer) begin
                        state      <= T_PRESET_2;
                        preset_min <= 4'(`TIMER_PRESET_2);
                    end else if (sel_cnt == '0) begin
                        state <= T_LOAD;
                    end
                end
                T_PRESET_2: begin
                    if (press_timer) begin
                        state      <= T_PRESET_3;
                        preset_min <= 4'(`TIMER_PRESET_3);
                    end else if (sel_cnt == '0) begin
                        state <= T_LOAD;
                    end
                end
                T_PRESET_3: begin
                    if (press_timer) begin
                        state <= T_IDLE;            // wrapped past last preset
                    end else if (sel_cnt == '0) begin
                        state <= T_LOAD;
                    end
                end
                T_LOAD: state <= T_RUN;
                T_RUN: begin
                    if (press_timer || !fan_on || finish) begin
                        state <= T_IDLE;
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sel_cnt <= '0;
        end else if (press_timer) begin
            sel_cnt <= sel_full;                    // each press reopens the window
        end else if (tick.ms && sel_cnt != '0) begin
            sel_cnt <= sel_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // mm:ss down-counter, one borrow chain
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            run_time <= '0;
        end else if (state == T_LOAD) begin
            run_time <= '{min10: 4'd0, min1: preset_min, sec10: 4'd0, sec1: 4'd0};
        end else if (state == T_RUN && tick.sec && !finish) begin
            if (run_time.sec1 != 4'd0) begin
                run_time.sec1 <= run_time.sec1 - 4'd1;
            end else begin
                run_time.sec1 <= 4'd9;
                if (run_time.sec10 != 4'd0) begin
                    run_time.sec10 <= run_time.sec10 - 4'd1;
                end else begin
                    run_time.sec10 <= 4'd5;         // seconds tens wrap at 6
                    if (run_time.min1 != 4'd0) begin
                        run_time.min1 <= run_time.min1 - 4'd1;
                    end else begin
                        run_time.min1  <= 4'd9;
                        run_time.min10 <= run_time.min10 - 4'd1;
                    end
                end
            end
        end
    end

    // a cancel in the same cycle wins over the finish
    assign finish = (state == T_RUN) && (run_time == 16'h0000) && fan_on && !press_timer;

    always_comb begin
        case (state)
            T_PRESET_1, T_PRESET_2, T_PRESET_3:
                value = '{min10: 4'd0, min1: preset_min, sec10: 4'd0, sec1: 4'd0};
            T_LOAD, T_RUN:
                value = run_time;
            default:
                value = '0;
        endcase
    end

    // finish only right after the second tick that ran the countdown out
    a_finish_in_run: assert property (@(posedge clk) disable iff (reset_p)
        finish |-> $past(state == T_RUN && tick.sec));

endmodule

`default_nettype wire

/* hdl/seg_display.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module seg_display import fan_disp_pkg::*; (
    input  logic       clk,
    input  logic       reset_p,
    input  bcd_time_t  value,
    output logic [3:0] com,
    output logic [7:0] seg_7
);

    localparam int scw = $clog2(`SCAN_CLKS + 1);
    localparam logic [scw-1:0] scan_last = scw'(`SCAN_CLKS - 1);

    logic [scw-1:0] scan_cnt;
    logic [1:0]     digit_idx;  // 0 is min10, leftmost
    logic [1:0]     next_idx;
    logic [3:0]     nibble;
    logic [6:0]     seg_on;     // gfedcba, active high

    assign next_idx = digit_idx + 2'd1;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= 2'd3;      // first step lands on min10
            com       <= 4'b1111;
        end else if (scan_cnt == scan_last) begin
            scan_cnt  <= '0;
            digit_idx <= next_idx;
            com       <= ~(4'b1000 >> next_idx);
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        case (digit_idx)
            2'd0:    nibble = value.min10;
            2'd1:    nibble = value.min1;
            2'd2:    nibble = value.sec10;
            default: nibble = value.sec1;
        endcase
    end

    always_comb begin
        case (nibble)
            4'd0:    seg_on = 7'h3f;
            4'd1:    seg_on = 7'h06;
            4'd2:    seg_on = 7'h5b;
            4'd3:    seg_on = 7'h4f;
            4'd4:    seg_on = 7'h66;
            4'd5:    seg_on = 7'h6d;
            4'd6:    seg_on = 7'h7d;
            4'd7:    seg_on = 7'h07;
            4'd8:    seg_on = 7'h7f;
            4'd9:    seg_on = 7'h6f;
            default: seg_on = 7'h00;    // blank
        endcase
    end

    assign seg_7 = {1'b1, ~seg_on};    // dp stays dark

endmodule

`default_nettype wire

/* hdl/fan_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module fan_top import fan_ctrl_pkg::*, fan_disp_pkg::*; #(
    parameter int clks_per_ms = `CLKS_PER_MS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [2:0] btn,         // 0 fan, 1 light, 2 timer
    output logic [2:0] status_led,
    output logic       motor_pwm,
    output logic       light_pwm,
    output logic [3:0] com,
    output logic [7:0] seg_7
);

    button_evt_t press;
    tick_t       tick;
    logic        fan_on;
    logic        finish;
    bcd_time_t   value;

    button_edge u_button_edge (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn),
        .press   (press)
    );

    tick_gen #(
        .clks_per_ms (clks_per_ms)
    ) u_tick_gen (
        .clk     (clk),
        .reset_p (reset_p),
        .tick    (tick)
    );

    fan_speed_fsm u_fan (
        .clk        (clk),
        .reset_p    (reset_p),
        .press_fan  (press.fan),
        .finish     (finish),
        .fan_on     (fan_on),
        .status_led (status_led),
        .motor_pwm  (motor_pwm)
    );

    mood_light u_light (
        .clk         (clk),
        .reset_p     (reset_p),
        .press_light (press.light),
        .light_pwm   (light_pwm)
    );

    off_timer u_timer (
        .clk         (clk),
        .reset_p     (reset_p),
        .press_timer (press.timer),
        .tick        (tick),
        .fan_on      (fan_on),
        .finish      (finish),
        .value       (value)
    );

    seg_display u_display (
        .clk     (clk),
        .reset_p (reset_p),
        .value   (value),
        .com     (com),
        .seg_7   (seg_7)
    );

endmodule

`default_nettype wire

/* dv/fan_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fan_params.svh"

module fan_tb;

    localparam int clks_per_ms = 2;     // one timer minute in 120000 clocks
    localparam int drive_delay = 2;

    logic       clk;
    logic       reset_p;
    logic [2:0] btn;
    logic [2:0] status_led;
    logic       motor_pwm;
    logic       light_pwm;
    logic [3:0] com;
    logic [7:0] seg_7;

    logic [7:0] cmd_q[$];
    int         arg_a_q[$];
    int         arg_b_q[$];
    int         cmd_idx;
    int         cycle_limit;
    int         cycle_cnt;
    logic       limit_ready;

    fan_top #(
        .clks_per_ms (clks_per_ms)
    ) u_dut (
        .clk        (clk),
        .reset_p    (reset_p),
        .btn        (btn),
        .status_led (status_led),
        .motor_pwm  (motor_pwm),
        .light_pwm  (light_pwm),
        .com        (com),
        .seg_7      (seg_7)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            stop_with_failure($sformatf("Error at %0d ns: %s, got %0d, expected %0d",
                $time, what, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        if (limit_ready) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > cycle_limit) begin
                stop_with_failure($sformatf("Timeout: run did not end within %0d clocks",
                    cycle_limit));
            end
        end
    end

    // one-hot leds per fan level, dark when off
    function automatic int expected_leds(input int level);
        if (level == 0) begin
            return 0;
        end
        return 1 << (level - 1);
    endfunction

    // active-low gfedcba with the dp bit dark
    function automatic int seg_to_digit(input logic [7:0] seg);
        case (seg)
            8'hc0:   return 0;
            8'hf9:   return 1;
            8'ha4:   return 2;
            8'hb0:   return 3;
            8'h99:   return 4;
            8'h92:   return 5;
            8'h82:   return 6;
            8'hf8:   return 7;
            8'h80:   return 8;
            8'h90:   return 9;
            default: return -1;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic step_clock(input int n);
        repeat (n) begin
            @(posedge clk);
            #(drive_delay);
        end
    endtask

    task automatic press_button(input int idx, input int hold);
        btn[idx] = 1'b1;
        step_clock(hold);
        btn[idx] = 1'b0;
        step_clock(hold);       // low long enough for the next edge
    endtask

    task automatic measure_pwm(input int sel, output int high_cnt);
        high_cnt = 0;
        repeat (`FAN_PWM_PERIOD) begin
            if ((sel == 1 && light_pwm) || (sel != 1 && motor_pwm)) begin
                high_cnt++;
            end
            step_clock(1);
        end
    endtask

    task automatic read_digits(output int shown);
        int         k;
        int         tries;
        int         digit;
        logic [3:0] sel_pattern;
        shown = 0;
        for (k = 0; k < 4; k++) begin
            case (k)
                0:       sel_pattern = 4'b0111;     // min10 first
                1:       sel_pattern = 4'b1011;
                2:       sel_pattern = 4'b1101;
                default: sel_pattern = 4'b1110;
            endcase
            tries = 0;
            while (com != sel_pattern && tries < 4 * `SCAN_CLKS + 8) begin
                step_clock(1);
                tries++;
            end
            if (com != sel_pattern) begin
                stop_with_failure("the digit select lines never lit the expected digit");
            end
            digit = seg_to_digit(seg_7);
            if (digit < 0) begin
                stop_with_failure($sformatf("segment pattern %h is not a decimal digit", seg_7));
            end
            shown = shown * 10 + digit;
        end
    endtask

    // a tick inside one scan can tear a read, a third read is then clean
    task automatic capture_display(output int shown);
        int first;
        int second;
        read_digits(first);
        read_digits(second);
        if (first == second) begin
            shown = first;
        end else begin
            read_digits(shown);
        end
    endtask

    task automatic wait_fan_off(input int limit);
        int n;
        n = 0;
        while (status_led != 3'b000 && n < limit) begin
            step_clock(1);
            n++;
        end
        if (status_led != 3'b000) begin
            stop_with_failure("the fan did not switch off before the finish wait ran out");
        end
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        int         a;
        int         b;
        int         wait_sum;
        logic [7:0] c;
        string      line;
        wait_sum = 0;
        fd = $fopen("dv/fan_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the stimulus file dv/fan_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %d %d", c, a, b);
            if (n == 3 && c != "#") begin
                cmd_q.push_back(c);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
                if (c == "p") begin
                    wait_sum += 2 * b;
                end else if (c == "w" || c == "e") begin
                    wait_sum += a;
                end
            end
        end
        $fclose(fd);
        if (cmd_q.size() == 0) begin
            stop_with_failure("the stimulus file holds no commands");
        end
        cycle_limit = (wait_sum * 3) / 2 + 200000;
    endtask

    task automatic run_command(input logic [7:0] cmd, input int a, input int b);
        int    result;
        string what;
        case (cmd)
            "p": press_button(a, b);
            "w": step_clock(a);
            "f": check_value(status_led, expected_leds(a), "status LEDs for fan level");
            "m": begin
                what = (a == 1) ? "light PWM high clocks" : "motor PWM high clocks";
                measure_pwm(a, result);
                check_value(result, b, what);
            end
            "d": begin
                capture_display(result);
                check_value(result, a, "displayed mmss");
            end
            "r": begin
                capture_display(result);
                what = $sformatf("displayed mmss %0d within %0d to %0d", result, a, b);
                check_value(result >= a && result <= b, 1, what);
            end
            "e": wait_fan_off(a);
            default: stop_with_failure($sformatf("unknown stimulus command %c", cmd));
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        reset_p     = 1'b1;
        btn         = 3'b000;
        cycle_cnt   = 0;
        limit_ready = 1'b0;
        load_stimulus();
        limit_ready = 1'b1;
        repeat (4) @(posedge clk);
        #(drive_delay);
        reset_p = 1'b0;
        for (cmd_idx = 0; cmd_idx < cmd_q.size(); cmd_idx++) begin
            run_command(cmd_q[cmd_idx], arg_a_q[cmd_idx], arg_b_q[cmd_idx]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/fan_stimulus.txt */
# columns: command, first number, second number; p btn clocks_held, w clocks, f fan_level,
# m pwm (0 motor, 1 light) high_clocks, d mmss, r mmss_low mmss_high, e clock_limit
f 0 0
m 0 0
p 0 120
f 1 0
m 0 30
p 0 120
f 2 0
m 0 50
p 0 120
f 3 0
m 0 80
p 0 120
f 0 0
m 0 0
# mood light with the fan at speed 1
p 0 120
p 1 120
m 1 33
p 1 120
m 1 66
p 1 120
m 1 99
p 1 120
m 1 0
f 1 0
m 0 30
# preset choice, every press inside the select window
d 0 0
p 2 8
d 100 0
p 2 8
d 300 0
p 2 8
d 500 0
p 2 8
d 0 0
w 1500 0
d 0 0
# one minute countdown to finish
p 2 8
d 100 0
w 9200 0
r 50 59
w 20000 0
r 40 49
e 130000 0
f 0 0
d 0 0
w 200 0
m 0 0
# cancel by a timer press, then by switching the fan off
p 0 120
p 2 8
w 1200 0
r 59 100
p 2 8
d 0 0
f 1 0
p 2 8
w 1200 0
r 59 100
p 0 120
p 0 120
p 0 120
f 0 0
d 0 0

/* verilog.f */
+incdir+hdl
hdl/fan_ctrl_pkg.sv
hdl/fan_disp_pkg.sv
hdl/tick_gen.sv
hdl/button_edge.sv
hdl/pwm_gen.sv
hdl/fan_speed_fsm.sv
hdl/mood_light.sv
hdl/off_timer.sv
hdl/seg_display.sv
hdl/fan_top.sv
dv/fan_tb.sv
